// File: ceu_v2p_pkg.sv
// shared widths, queue sizes, request encodings and header decode for the v2p request parser
`default_nettype none

package ceu_v2p_pkg;

    // ------------------------------------------------------------
    // stream and header widths
    // ------------------------------------------------------------
    localparam int hd_width     = 128;
    localparam int dt_width     = 256;
    localparam int type_width   = 4;
    localparam int opcode_width = 4;

    // queue depths
    localparam int hdr_depth      = 16;
    localparam int mpt_data_depth = 64;
    localparam int mtt_data_depth = 256;
    localparam int mdata_depth    = 256;
    // almost-full at depth - 4, covers the registered write stage
    localparam int afull_margin   = 4;

    // ------------------------------------------------------------
    // header encodings
    // ------------------------------------------------------------
    // type field, top 4 header bits
    typedef enum logic [type_width-1:0] {
        wr_mpt_tpt    = 4'd1,
        wr_mtt_tpt    = 4'd2,
        wr_icmmap_tpt = 4'd3,
        map_icm_tpt   = 4'd4
    } req_type_e;

    // opcode field, next 4 bits
    // mpt_write, mtt_write, icmmap_en and map_icm_en all encode as 1
    // mpt_invalid, icmmap_dis and map_icm_dis all encode as 2
    typedef enum logic [opcode_width-1:0] {
        op_write   = 4'd1,
        op_invalid = 4'd2
    } req_opcode_e;

    // enable/disable aliases for the mdata types
    localparam req_opcode_e op_en  = op_write;
    localparam req_opcode_e op_dis = op_invalid;

    typedef enum logic [1:0] {
        dest_none,
        dest_mpt,
        dest_mtt,
        dest_mdata
    } dest_e;

    typedef struct packed {
        dest_e dest;
        logic  with_payload;
    } route_t;

    typedef enum logic {
        st_parse,
        st_forward
    } parse_state_e;

    // type/opcode to destination; unknown pairs map to dest_none
    function automatic route_t decode_route(input logic [hd_width-1:0] hdr);
        req_type_e   typ;
        req_opcode_e op;
        route_t      r;
        typ = req_type_e'(hdr[hd_width-1 -: type_width]);
        op  = req_opcode_e'(hdr[hd_width-type_width-1 -: opcode_width]);
        r.dest         = dest_none;
        r.with_payload = 1'b0;
        case (typ)
            wr_mpt_tpt: begin
                if (op == op_write || op == op_invalid) begin
                    r.dest         = dest_mpt;
                    r.with_payload = (op == op_write);
                end
            end
            wr_mtt_tpt: begin
                if (op == op_write) begin
                    r.dest         = dest_mtt;
                    r.with_payload = 1'b1;
                end
            end
            wr_icmmap_tpt, map_icm_tpt: begin
                if (op == op_en || op == op_dis) begin
                    r.dest         = dest_mdata;
                    r.with_payload = (op == op_en);
                end
            end
            default: r.dest = dest_none;
        endcase
        return r;
    endfunction

endpackage

`default_nettype wire

// File: dest_wr_if.sv
// write bundle from the parser into one destination's header and payload queues
`default_nettype none

interface dest_wr_if;
    import ceu_v2p_pkg::*;

    // header queue side
    logic                hdr_wr;
    logic [hd_width-1:0] hdr_din;
    logic                hdr_afull;

    // payload queue side
    logic                data_wr;
    logic [dt_width-1:0] data_din;
    logic                data_afull;

    // parser end
    modport src (
        output hdr_wr, hdr_din, data_wr, data_din,
        input  hdr_afull, data_afull
    );

    // queue end
    modport sink (
        input  hdr_wr, hdr_din, data_wr, data_din,
        output hdr_afull, data_afull
    );

endinterface

`default_nettype wire

// File: sync_fifo.sv
// first-word-fall-through register queue with almost-full flag, used for all destination queues
`default_nettype none

module sync_fifo #(
    parameter int width       = 32,
    parameter int depth       = 16,
    parameter int afull_level = 12
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wr_en,
    input  logic [width-1:0] din,
    input  logic             rd_en,
    output logic [width-1:0] dout,
    output logic             empty,
    output logic             afull
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam int cw = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [aw-1:0]    wr_ptr;
    logic [aw-1:0]    rd_ptr;
    logic [cw-1:0]    count;
    logic             do_wr;
    logic             do_rd;

    // ------------------------------------------------------------
    // flags
    // ------------------------------------------------------------
    assign empty = (count == '0);
    assign afull = (count >= cw'(afull_level));
    // drop writes into a full queue, reads of an empty one
    assign do_wr = wr_en && (count != cw'(depth));
    assign do_rd = rd_en && !empty;

    // head entry shows without a read strobe
    assign dout = mem[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // ------------------------------------------------------------
    // pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous read and write keeps the count
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // almost-full margin must absorb the writer's pipeline
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst) wr_en |-> (count != cw'(depth))
    ) else $error("write into a full queue");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst) rd_en |-> !empty
    ) else $error("read from an empty queue");

endmodule

`default_nettype wire

// File: ceu_req_parser.sv
// splits the request stream into per-destination header and payload queue writes
`default_nettype none

module ceu_req_parser (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             tvalid,
    input  logic [ceu_v2p_pkg::dt_width-1:0] tdata,
    input  logic                             tlast,
    input  logic [ceu_v2p_pkg::hd_width-1:0] theader,
    output logic                             tready,
    dest_wr_if.src                           mpt,
    dest_wr_if.src                           mtt,
    dest_wr_if.src                           mdata
);
    import ceu_v2p_pkg::*;

    parse_state_e        state;
    route_t              route_q;
    route_t              route_cur;
    logic [hd_width-1:0] hdr_q;
    logic [dt_width-1:0] data_q;
    logic                last_q;
    logic                ready_en;
    logic [3:1]          data_wr_q;
    logic [3:1]          hdr_wr_v;
    // bit 0 is dest_none and never stalls
    logic [3:0]          hdr_afull_v;
    logic [3:0]          data_afull_v;
    logic                any_afull;
    logic                accept;
    logic                hdr_go;

    // ------------------------------------------------------------
    // almost-full levels by destination
    // ------------------------------------------------------------
    assign hdr_afull_v  = {mdata.hdr_afull, mtt.hdr_afull, mpt.hdr_afull, 1'b0};
    assign data_afull_v = {mdata.data_afull, mtt.data_afull, mpt.data_afull, 1'b0};
    assign any_afull    = (|hdr_afull_v) || (|data_afull_v);

    // live header on the first beat, latched one after that
    assign route_cur = (state == st_parse) ? decode_route(theader) : route_q;

    // ------------------------------------------------------------
    // ready
    // ------------------------------------------------------------
    always_comb begin
        case (state)
            // a new packet waits until every queue has room
            st_parse:   tready = ready_en && !any_afull;
            // payload beats stall only on their own data queue
            st_forward: tready = !last_q &&
                                 !(route_cur.with_payload && data_afull_v[route_cur.dest]);
            default:    tready = 1'b0;
        endcase
    end

    assign accept = tvalid && tready;

    // header write after the last beat, held while its queue is almost-full
    assign hdr_go = (state == st_forward) && last_q && !hdr_afull_v[route_q.dest];

    // only the routed destination gets the header
    always_comb begin
        hdr_wr_v = '0;
        if (hdr_go && route_q.dest != dest_none) begin
            hdr_wr_v[route_q.dest] = 1'b1;
        end
    end

    // ------------------------------------------------------------
    // state, route and last flag
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_parse;
            route_q   <= '{dest: dest_none, with_payload: 1'b0};
            last_q    <= 1'b0;
            ready_en  <= 1'b0;
            data_wr_q <= '0;
        end else begin
            ready_en  <= 1'b1;
            // one beat in, one registered write out
            data_wr_q <= '0;
            if (accept && route_cur.with_payload) begin
                data_wr_q[route_cur.dest] <= 1'b1;
            end
            case (state)
                st_parse: begin
                    if (accept) begin
                        state   <= st_forward;
                        route_q <= route_cur;
                        last_q  <= tlast;
                    end
                end
                st_forward: begin
                    // dest_none leaves here too, with nothing written
                    if (hdr_go) begin
                        state  <= st_parse;
                        last_q <= 1'b0;
                    end else if (accept && tlast) begin
                        last_q <= 1'b1;
                    end
                end
                default: state <= st_parse;
            endcase
        end
    end

    // header and beat holding registers
    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= tdata;
        end
        if (accept && state == st_parse) begin
            hdr_q <= theader;
        end
    end

    // ------------------------------------------------------------
    // write bundles
    // ------------------------------------------------------------
    assign mpt.hdr_wr    = hdr_wr_v[1];
    assign mpt.hdr_din   = hdr_q;
    assign mpt.data_wr   = data_wr_q[1];
    assign mpt.data_din  = data_q;

    assign mtt.hdr_wr    = hdr_wr_v[2];
    assign mtt.hdr_din   = hdr_q;
    assign mtt.data_wr   = data_wr_q[2];
    assign mtt.data_din  = data_q;

    assign mdata.hdr_wr   = hdr_wr_v[3];
    assign mdata.hdr_din  = hdr_q;
    assign mdata.data_wr  = data_wr_q[3];
    assign mdata.data_din = data_q;

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    // input closed from the last beat until the parser is back in parse
    a_no_beat_after_last: assert property (
        @(posedge clk) disable iff (rst)
        accept && tlast |=> !tready until (state == st_parse)
    ) else $error("tready high after the last beat");

    // one header per packet, none again before the next first beat
    a_one_hdr_dest: assert property (
        @(posedge clk) disable iff (rst)
        |hdr_wr_v |=> !(|hdr_wr_v) until (state == st_parse && accept)
    ) else $error("header written more than once for one packet");

    // payload lands only in the queue latched for this packet
    a_one_data_dest: assert property (
        @(posedge clk) disable iff (rst)
        |data_wr_q |-> route_q.with_payload &&
                       (data_wr_q == (3'b001 << (route_q.dest - 1)))
    ) else $error("payload written to a destination other than the packet's");

    // header goes out in forward and no beat of its packet trails it
    a_hdr_in_forward: assert property (
        @(posedge clk) disable iff (rst)
        |hdr_wr_v |-> (state == st_forward) ##1 !(|data_wr_q)
    ) else $error("header write outside forward state or ahead of its payload");

endmodule

`default_nettype wire

// File: ceu_parser_v2p.sv
// top level of the v2p request parser: parser plus six destination queues on plain ports
`default_nettype none

module ceu_parser_v2p (
    input  logic                             clk,
    input  logic                             rst,

    // request stream from the control unit
    input  logic                             ceu_req_tvalid,
    output logic                             ceu_req_tready,
    input  logic [ceu_v2p_pkg::dt_width-1:0] ceu_req_tdata,
    input  logic                             ceu_req_tlast,
    input  logic [ceu_v2p_pkg::hd_width-1:0] ceu_req_theader,

    // mpt header and payload
    input  logic                             mpt_req_rd_en,
    output logic [ceu_v2p_pkg::hd_width-1:0] mpt_req_dout,
    output logic                             mpt_req_empty,
    input  logic                             mpt_data_rd_en,
    output logic [ceu_v2p_pkg::dt_width-1:0] mpt_data_dout,
    output logic                             mpt_data_empty,

    // mtt header and payload
    input  logic                             mtt_req_rd_en,
    output logic [ceu_v2p_pkg::hd_width-1:0] mtt_req_dout,
    output logic                             mtt_req_empty,
    input  logic                             mtt_data_rd_en,
    output logic [ceu_v2p_pkg::dt_width-1:0] mtt_data_dout,
    output logic                             mtt_data_empty,

    // metadata header and payload
    input  logic                             mdata_req_rd_en,
    output logic [ceu_v2p_pkg::hd_width-1:0] mdata_req_dout,
    output logic                             mdata_req_empty,
    input  logic                             mdata_rd_en,
    output logic [ceu_v2p_pkg::dt_width-1:0] mdata_dout,
    output logic                             mdata_empty
);
    import ceu_v2p_pkg::*;

    dest_wr_if mpt_if ();
    dest_wr_if mtt_if ();
    dest_wr_if mdata_if ();

    ceu_req_parser u_parser (
        .clk     (clk),
        .rst     (rst),
        .tvalid  (ceu_req_tvalid),
        .tdata   (ceu_req_tdata),
        .tlast   (ceu_req_tlast),
        .theader (ceu_req_theader),
        .tready  (ceu_req_tready),
        .mpt     (mpt_if),
        .mtt     (mtt_if),
        .mdata   (mdata_if)
    );

    // ------------------------------------------------------------
    // header queues
    // ------------------------------------------------------------
    sync_fifo #(
        .width       (hd_width),
        .depth       (hdr_depth),
        .afull_level (hdr_depth - afull_margin)
    ) u_mpt_req_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr_en (mpt_if.hdr_wr),
        .din   (mpt_if.hdr_din),
        .rd_en (mpt_req_rd_en),
        .dout  (mpt_req_dout),
        .empty (mpt_req_empty),
        .afull (mpt_if.hdr_afull)
    );

    sync_fifo #(
        .width       (hd_width),
        .depth       (hdr_depth),
        .afull_level (hdr_depth - afull_margin)
    ) u_mtt_req_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr_en (mtt_if.hdr_wr),
        .din   (mtt_if.hdr_din),
        .rd_en (mtt_req_rd_en),
        .dout  (mtt_req_dout),
        .empty (mtt_req_empty),
        .afull (mtt_if.hdr_afull)
    );

    sync_fifo #(
        .width       (hd_width),
        .depth       (hdr_depth),
        .afull_level (hdr_depth - afull_margin)
    ) u_mdata_req_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr_en (mdata_if.hdr_wr),
        .din   (mdata_if.hdr_din),
        .rd_en (mdata_req_rd_en),
        .dout  (mdata_req_dout),
        .empty (mdata_req_empty),
        .afull (mdata_if.hdr_afull)
    );

    // ------------------------------------------------------------
    // payload queues
    // ------------------------------------------------------------
    sync_fifo #(
        .width       (dt_width),
        .depth       (mpt_data_depth),
        .afull_level (mpt_data_depth - afull_margin)
    ) u_mpt_data_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr_en (mpt_if.data_wr),
        .din   (mpt_if.data_din),
        .rd_en (mpt_data_rd_en),
        .dout  (mpt_data_dout),
        .empty (mpt_data_empty),
        .afull (mpt_if.data_afull)
    );

    sync_fifo #(
        .width       (dt_width),
        .depth       (mtt_data_depth),
        .afull_level (mtt_data_depth - afull_margin)
    ) u_mtt_data_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr_en (mtt_if.data_wr),
        .din   (mtt_if.data_din),
        .rd_en (mtt_data_rd_en),
        .dout  (mtt_data_dout),
        .empty (mtt_data_empty),
        .afull (mtt_if.data_afull)
    );

    sync_fifo #(
        .width       (dt_width),
        .depth       (mdata_depth),
        .afull_level (mdata_depth - afull_margin)
    ) u_mdata_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr_en (mdata_if.data_wr),
        .din   (mdata_if.data_din),
        .rd_en (mdata_rd_en),
        .dout  (mdata_dout),
        .empty (mdata_empty),
        .afull (mdata_if.data_afull)
    );

endmodule

`default_nettype wire

// File: tb_ceu_parser_v2p.sv
// self-checking testbench for the v2p request parser, run as the simulation top
`default_nettype none

module tb_ceu_parser_v2p;
    timeunit 1ns;
    timeprecision 1ps;
    import ceu_v2p_pkg::*;

    // 300 packets take about 2000 cycles including the stall phase
    localparam int n_packets  = 300;
    localparam int max_cycles = 4000;

    logic                clk             = 1'b0;
    logic                rst             = 1'b1;
    logic                ceu_req_tvalid  = 1'b0;
    logic                ceu_req_tready;
    logic [dt_width-1:0] ceu_req_tdata   = '0;
    logic                ceu_req_tlast   = 1'b0;
    logic [hd_width-1:0] ceu_req_theader = '0;
    logic                mpt_req_rd_en   = 1'b0;
    logic                mpt_data_rd_en  = 1'b0;
    logic                mtt_req_rd_en   = 1'b0;
    logic                mtt_data_rd_en  = 1'b0;
    logic                mdata_req_rd_en = 1'b0;
    logic                mdata_rd_en     = 1'b0;
    logic [hd_width-1:0] mpt_req_dout;
    logic [hd_width-1:0] mtt_req_dout;
    logic [hd_width-1:0] mdata_req_dout;
    logic [dt_width-1:0] mpt_data_dout;
    logic [dt_width-1:0] mtt_data_dout;
    logic [dt_width-1:0] mdata_dout;
    logic                mpt_req_empty;
    logic                mtt_req_empty;
    logic                mdata_req_empty;
    logic                mpt_data_empty;
    logic                mtt_data_empty;
    logic                mdata_empty;

    // expected traffic, index 1 mpt, 2 mtt, 3 mdata
    logic [hd_width-1:0] exp_hdr  [4][$];
    logic [dt_width-1:0] exp_data [4][$];
    // beats owed to each destination once a header is out
    int                  exp_cum  [4][$];
    int                  data_sent   [4] = '{0, 0, 0, 0};
    int                  data_popped [4] = '{0, 0, 0, 0};

    logic [31:0] stim_lfsr  = 32'h2318;
    logic [31:0] stall_lfsr = 32'h2318;
    int          val_errs   = 0;
    int          other_errs = 0;
    int          cycles     = 0;
    int          low_run    = 0;
    logic        reads_on   = 1'b0;
    logic        start_send = 1'b0;
    logic        send_done  = 1'b0;

    always #5 clk = ~clk;

    ceu_parser_v2p dut0 (.*);

    // ------------------------------------------------------------
    // random source, x^32 + x^22 + x^2 + x + 1
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] stim_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    // separate stream so reads never disturb the stimulus
    function automatic logic [31:0] stall_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            stall_lfsr = lfsr_next(stall_lfsr);
            v = {v[30:0], stall_lfsr[0]};
        end
        return v;
    endfunction

    // expected routing from type/opcode: {dest, with_payload}, dest 0 means dropped
    function automatic logic [2:0] ref_route(input logic [hd_width-1:0] hdr);
        logic [3:0] t;
        logic [3:0] op;
        t  = hdr[127:124];
        op = hdr[123:120];
        if (t == 4'd1 && op == 4'd1) return {2'd1, 1'b1};
        if (t == 4'd1 && op == 4'd2) return {2'd1, 1'b0};
        if (t == 4'd2 && op == 4'd1) return {2'd2, 1'b1};
        if ((t == 4'd3 || t == 4'd4) && op == 4'd1) return {2'd3, 1'b1};
        if ((t == 4'd3 || t == 4'd4) && op == 4'd2) return {2'd3, 1'b0};
        return 3'b000;
    endfunction

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    function automatic logic [hd_width-1:0] make_header();
        logic [hd_width-1:0] h;
        logic [31:0]         r;
        int                  i;
        r = stim_bits(24);
        h[119:96] = r[23:0];
        for (i = 0; i < 3; i++) begin
            h[i*32 +: 32] = stim_bits(32);
        end
        // mostly legal kinds, one in eight is junk
        case (stim_bits(3))
            3'd0:    h[127:120] = 8'h11;
            3'd1:    h[127:120] = 8'h12;
            3'd2:    h[127:120] = 8'h21;
            3'd3:    h[127:120] = 8'h31;
            3'd4:    h[127:120] = 8'h32;
            3'd5:    h[127:120] = 8'h41;
            3'd6:    h[127:120] = 8'h42;
            default: begin
                r = stim_bits(8);
                h[127:120] = r[7:0];
            end
        endcase
        return h;
    endfunction

    function automatic logic [dt_width-1:0] make_word();
        logic [dt_width-1:0] w;
        int                  i;
        for (i = 0; i < 8; i++) begin
            w[i*32 +: 32] = stim_bits(32);
        end
        return w;
    endfunction

    task automatic send_packet();
        logic [hd_width-1:0] hdr;
        logic [dt_width-1:0] word;
        logic [2:0]          r;
        int                  beats;
        int                  d;
        int                  i;
        hdr   = make_header();
        beats = 1 + int'(stim_bits(2));
        r     = ref_route(hdr);
        d     = int'(r[2:1]);
        if (d != 0) begin
            if (r[0]) begin
                data_sent[d] += beats;
            end
            exp_hdr[d].push_back(hdr);
            exp_cum[d].push_back(data_sent[d]);
        end
        for (i = 0; i < beats; i++) begin
            word = make_word();
            if (d != 0 && r[0]) begin
                exp_data[d].push_back(word);
            end
            ceu_req_tvalid  = 1'b1;
            ceu_req_tdata   = word;
            ceu_req_tlast   = (i == beats - 1);
            // header only counts on the first beat
            ceu_req_theader = (i == 0) ? hdr : ~hdr;
            // tready only moves on posedge, stable here
            while (!ceu_req_tready) begin
                @(negedge clk);
            end
            @(negedge clk);
        end
        ceu_req_tvalid = 1'b0;
    endtask

    initial begin
        wait (start_send);
        repeat (n_packets) begin
            send_packet();
            // occasional idle cycle between packets
            if (stim_bits(2) == 0) begin
                @(negedge clk);
            end
        end
        send_done = 1'b1;
    end

    // ------------------------------------------------------------
    // readers and compare
    // ------------------------------------------------------------
    function automatic logic pop_hdr(input int d, input logic [hd_width-1:0] dout,
                                     input logic empty, input logic data_empty,
                                     input string name);
        logic [hd_width-1:0] exp;
        int                  cum;
        if (empty || !reads_on || stall_bits(2) == 0) return 1'b0;
        if (exp_hdr[d].size() == 0) begin
            other_errs++;
            $display("%0t: unexpected header on %s", $time, name);
            return 1'b1;
        end
        exp = exp_hdr[d].pop_front();
        cum = exp_cum[d].pop_front();
        if (dout !== exp) begin
            val_errs++;
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, dout);
        end
        // payload must already sit in the data queue
        if (cum > data_popped[d] && data_empty) begin
            other_errs++;
            $display("%0t: header on %s came out before its payload", $time, name);
        end
        return 1'b1;
    endfunction

    function automatic logic pop_data(input int d, input logic [dt_width-1:0] dout,
                                      input logic empty, input string name);
        logic [dt_width-1:0] exp;
        if (empty || !reads_on || stall_bits(2) == 0) return 1'b0;
        data_popped[d]++;
        if (exp_data[d].size() == 0) begin
            other_errs++;
            $display("%0t: unexpected payload beat on %s", $time, name);
            return 1'b1;
        end
        exp = exp_data[d].pop_front();
        if (dout !== exp) begin
            val_errs++;
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, dout);
        end
        return 1'b1;
    endfunction

    always @(negedge clk) begin
        if (!rst) begin
            low_run = ceu_req_tready ? 0 : low_run + 1;
            // reads held off until the input has been stalled a while
            if (!reads_on && low_run >= 20) begin
                reads_on = 1'b1;
            end
            // headers first so data_popped covers only earlier cycles
            mpt_req_rd_en   = pop_hdr(1, mpt_req_dout, mpt_req_empty, mpt_data_empty,
                                      "mpt_req_dout");
            mtt_req_rd_en   = pop_hdr(2, mtt_req_dout, mtt_req_empty, mtt_data_empty,
                                      "mtt_req_dout");
            mdata_req_rd_en = pop_hdr(3, mdata_req_dout, mdata_req_empty, mdata_empty,
                                      "mdata_req_dout");
            mpt_data_rd_en  = pop_data(1, mpt_data_dout, mpt_data_empty, "mpt_data_dout");
            mtt_data_rd_en  = pop_data(2, mtt_data_dout, mtt_data_empty, "mtt_data_dout");
            mdata_rd_en     = pop_data(3, mdata_dout, mdata_empty, "mdata_dout");
        end
    end

    function automatic logic all_dut_empty();
        return mpt_req_empty && mtt_req_empty && mdata_req_empty &&
               mpt_data_empty && mtt_data_empty && mdata_empty;
    endfunction

    function automatic logic all_exp_empty();
        int d;
        for (d = 1; d < 4; d++) begin
            if (exp_hdr[d].size() != 0 || exp_data[d].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    // ------------------------------------------------------------
    // run control
    // ------------------------------------------------------------
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run not finished after %0d cycles", max_cycles);
            $display("value errors: %0d, other errors: %0d", val_errs, other_errs);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        repeat (16) @(posedge clk);
        @(negedge clk);
        if (ceu_req_tready !== 1'b0) begin
            other_errs++;
            $display("%0t: tready high during reset", $time);
        end
        if (!all_dut_empty()) begin
            other_errs++;
            $display("%0t: a queue is not empty during reset", $time);
        end
        rst = 1'b0;
        @(negedge clk);
        if (ceu_req_tready !== 1'b1) begin
            other_errs++;
            $display("%0t: tready did not rise after reset release", $time);
        end
        start_send = 1'b1;
        // drain, then give stray writes time to show up
        while (!(send_done && all_exp_empty())) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
        if (!all_dut_empty()) begin
            other_errs++;
            $display("%0t: queues not empty at the end of the run", $time);
        end
        $display("value errors: %0d, other errors: %0d", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
ceu_v2p_pkg.sv
dest_wr_if.sv
sync_fifo.sv
ceu_req_parser.sv
ceu_parser_v2p.sv
tb_ceu_parser_v2p.sv

// File: Bender.yml
package:
  name: ceu_parser_v2p

sources:
  - ceu_v2p_pkg.sv
  - dest_wr_if.sv
  - sync_fifo.sv
  - ceu_req_parser.sv
  - ceu_parser_v2p.sv
  - target: test
    files:
      - tb_ceu_parser_v2p.sv
